/* src/vmul_cfg.svh */
/*
 Global sizes for the vector multiply unit.
 Only VLEN = 128 with 32-bit lane groups is supported by the datapath.
*/
`ifndef VMUL_CFG_SVH
`define VMUL_CFG_SVH

//////////////////////////////////////////////////
// architectural widths
//////////////////////////////////////////////////
`define VMUL_VLEN      128  // vector register width
`define VMUL_XLEN      32   // scalar operand width
`define VMUL_ROB_W     4    // reorder buffer index width

//////////////////////////////////////////////////
// lane geometry
//////////////////////////////////////////////////
`define VMUL_NUM_BYTES 16   // bytes per vector register
`define VMUL_GRP_BYTES 4    // bytes per 32-bit multiplier group

`endif

/* src/vmul_pkg.sv */
/*
 Types shared by the multiply datapath and its testbench.
 funct6 values follow the vector spec; vsmul reuses the vmulh code.
*/
`include "vmul_cfg.svh"

package vmul_pkg;

  typedef enum logic [2:0] {
    opivv = 3'b000,
    opmvv = 3'b010,
    opivx = 3'b100,
    opmvx = 3'b110
  } funct3_e;

  typedef enum logic [5:0] {
    vmulhu  = 6'b100100,
    vmul    = 6'b100101,
    vmulhsu = 6'b100110,
    vmulh   = 6'b100111
  } funct6_e;

  // vsmul under opi sits on the same funct6 code as vmulh under opm
  localparam funct6_e vsmul = vmulh;

  typedef enum logic [1:0] {rnu, rne, rdn, rod} vxrm_e;
  typedef enum logic [1:0] {eew8, eew16, eew32} eew_e;

  typedef struct packed {
    logic [`VMUL_ROB_W-1:0] rob_entry;
    funct3_e                funct3;
    funct6_e                funct6;
    vxrm_e                  vxrm;
    eew_e                   eew;
    logic [`VMUL_VLEN-1:0]  vs1_data;
    logic [`VMUL_VLEN-1:0]  vs2_data;
    logic [`VMUL_XLEN-1:0]  rs1_data;
  } mul_uop_t;

  typedef struct packed {
    logic [`VMUL_VLEN-1:0]      src2;
    logic [`VMUL_VLEN-1:0]      src1;
    logic [`VMUL_NUM_BYTES-1:0] src2_sign_bytes;  // top byte of signed elements
    logic [`VMUL_NUM_BYTES-1:0] src1_sign_bytes;
  } mul_ops_t;

  typedef struct packed {
    logic [`VMUL_ROB_W-1:0] rob_entry;
    logic                   keep_low;     // vmul low half
    logic                   is_vsmul;
    logic                   dst_signed;   // either operand signed
    logic                   src1_signed;  // src1 signed, needed for vmulhsu
    vxrm_e                  vxrm;
    eew_e                   eew;
  } mul_ctrl_t;

  // [group][src1 byte][src2 byte] 16-bit products
  typedef logic [`VMUL_NUM_BYTES/`VMUL_GRP_BYTES-1:0][`VMUL_GRP_BYTES-1:0]
                [`VMUL_GRP_BYTES-1:0][15:0] pp_vec_t;

  typedef struct packed {
    logic [`VMUL_NUM_BYTES-1:0][15:0]   p8;
    logic [`VMUL_NUM_BYTES/2-1:0][31:0] p16;
    logic [`VMUL_NUM_BYTES/4-1:0][63:0] p32;
  } full_prod_t;

  typedef struct packed {
    logic [`VMUL_ROB_W-1:0] rob_entry;
    logic [`VMUL_VLEN-1:0]  w_data;
    logic                   vxsat;
  } mul_rslt_t;

endpackage

/* src/mul_decode.sv */
/*
 Opcode decode and operand setup, purely combinational.
 Unknown funct6 maps to vmul (opm) or vsmul (opi); other funct3 gives zero.
 An eew code outside 8/16/32 is handled as eew8.
*/
`timescale 1ns/1ps
`include "vmul_cfg.svh"

module mul_decode (
  input  logic                uop_valid,
  input  vmul_pkg::mul_uop_t  uop,
  output vmul_pkg::mul_ops_t  ops,
  output vmul_pkg::mul_ctrl_t ctrl
);
  import vmul_pkg::*;

  logic                       src2_signed;
  logic                       src1_signed;
  logic                       keep_low;
  logic                       is_vsmul;
  logic                       use_vv;    // vs1 else broadcast rs1
  logic                       op_en;     // supported and valid
  logic [`VMUL_VLEN-1:0]      bcast;
  logic [`VMUL_NUM_BYTES-1:0] top_mask;  // msb byte of each element

  //////////////////////////////////////////////////
  // opcode decode
  //////////////////////////////////////////////////
  always_comb begin
    src2_signed = 1'b0;
    src1_signed = 1'b0;
    keep_low    = 1'b0;
    is_vsmul    = 1'b0;
    use_vv      = 1'b1;
    op_en       = 1'b0;
    if (uop_valid) begin
      case (uop.funct3)
        opmvv, opmvx: begin
          op_en  = 1'b1;
          use_vv = (uop.funct3 == opmvv);
          case (uop.funct6)
            vmulh: begin
              src2_signed = 1'b1;
              src1_signed = 1'b1;
            end
            vmulhu:  keep_low = 1'b0;     // unsigned high half
            vmulhsu: src2_signed = 1'b1;  // vs2 signed only
            default: begin                // vmul and unknown codes
              src2_signed = 1'b1;
              src1_signed = 1'b1;
              keep_low    = 1'b1;
            end
          endcase
        end
        opivv, opivx: begin               // any funct6 runs as vsmul
          op_en       = 1'b1;
          use_vv      = (uop.funct3 == opivv);
          is_vsmul    = 1'b1;
          src2_signed = 1'b1;
          src1_signed = 1'b1;
        end
        default: op_en = 1'b0;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // scalar broadcast and sign byte placement
  //////////////////////////////////////////////////
  always_comb begin
    case (uop.eew)
      eew32:   bcast = {(`VMUL_VLEN/32){uop.rs1_data[31:0]}};
      eew16:   bcast = {(`VMUL_VLEN/16){uop.rs1_data[15:0]}};
      default: bcast = {(`VMUL_VLEN/8){uop.rs1_data[7:0]}};
    endcase
    for (int i = 0; i < `VMUL_NUM_BYTES; i++) begin
      case (uop.eew)
        eew32:   top_mask[i] = (i % 4 == 3);
        eew16:   top_mask[i] = (i % 2 == 1);
        default: top_mask[i] = 1'b1;
      endcase
    end
  end

  always_comb begin
    ops.src2            = op_en ? uop.vs2_data : '0;
    ops.src1            = !op_en ? '0 : (use_vv ? uop.vs1_data : bcast);
    ops.src2_sign_bytes = top_mask & {`VMUL_NUM_BYTES{src2_signed}};
    ops.src1_sign_bytes = top_mask & {`VMUL_NUM_BYTES{src1_signed}};
    ctrl.rob_entry   = uop.rob_entry;
    ctrl.keep_low    = keep_low;
    ctrl.is_vsmul    = is_vsmul;
    ctrl.dst_signed  = src2_signed | src1_signed;
    ctrl.src1_signed = src1_signed;
    ctrl.vxrm        = uop.vxrm;
    ctrl.eew         = uop.eew;
  end

endmodule

/* src/mul_pp_array.sv */
/*
 8x8 partial product array and the single pipeline register of the unit.
 Each byte is widened to 9 bits by its own sign flag before multiplying.
 Product and ctrl registers load only on a valid uop and have no reset.
*/
`timescale 1ns/1ps
`include "vmul_cfg.svh"

module mul_pp_array (
  input  logic                clk,
  input  logic                reset,
  input  logic                uop_valid,
  input  vmul_pkg::mul_ops_t  ops,
  input  vmul_pkg::mul_ctrl_t ctrl,
  output logic                pp_valid,
  output vmul_pkg::pp_vec_t   pp,
  output vmul_pkg::mul_ctrl_t pp_ctrl
);
  import vmul_pkg::*;

  localparam int NUM_GRPS = `VMUL_NUM_BYTES / `VMUL_GRP_BYTES;
  localparam int GB       = `VMUL_GRP_BYTES;

  pp_vec_t pp_d;

  //////////////////////////////////////////////////
  // 4 groups of 4x4 byte products
  //////////////////////////////////////////////////
  always_comb begin
    logic signed [8:0]  a;
    logic signed [8:0]  b;
    logic signed [17:0] p;
    int                 ia;
    int                 ib;
    for (int g = 0; g < NUM_GRPS; g++) begin
      for (int y = 0; y < GB; y++) begin
        for (int x = 0; x < GB; x++) begin
          ia = g * GB + x;  // src2 byte
          ib = g * GB + y;  // src1 byte
          a = {ops.src2_sign_bytes[ia] & ops.src2[ia*8+7], ops.src2[ia*8 +: 8]};
          b = {ops.src1_sign_bytes[ib] & ops.src1[ib*8+7], ops.src1[ib*8 +: 8]};
          p = a * b;
          pp_d[g][y][x] = p[15:0];  // 16 bits hold every 9x9 case used here
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // pipeline register
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      pp_valid <= 1'b0;
    end else begin
      pp_valid <= uop_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (uop_valid) begin
      pp      <= pp_d;
      pp_ctrl <= ctrl;
    end
  end

endmodule

/* src/mul_assemble.sv */
/*
 Combines byte products into full 16/32/64-bit products per group.
 A cross term is sign-extended only when its upper byte came from a
 signed operand: src2 side follows dst_signed, src1 side src1_signed.
*/
`timescale 1ns/1ps
`include "vmul_cfg.svh"

module mul_assemble (
  input  vmul_pkg::pp_vec_t    pp,
  input  logic                 dst_signed,
  input  logic                 src1_signed,
  output vmul_pkg::full_prod_t prod
);
  import vmul_pkg::*;

  localparam int NUM_GRPS = `VMUL_NUM_BYTES / `VMUL_GRP_BYTES;
  localparam int GB       = `VMUL_GRP_BYTES;

  // sum of nb x nb terms starting at byte base of group g
  function automatic logic [63:0] sum_terms(
    input pp_vec_t pv,
    input int      g,
    input int      base,
    input int      nb,
    input logic    s2,
    input logic    s1
  );
    logic [63:0] acc;
    logic [15:0] t;
    logic        ext;
    acc = '0;
    for (int y = 0; y < nb; y++) begin
      for (int x = 0; x < nb; x++) begin
        t   = pv[g][base+y][base+x];
        // top x top term sits at the msb end and needs no extension
        ext = t[15] & ((x == nb - 1 && y != nb - 1 && s2) ||
                       (y == nb - 1 && x != nb - 1 && s1));
        acc = acc + ({{48{ext}}, t} << (8 * (x + y)));
      end
    end
    return acc;
  endfunction

  //////////////////////////////////////////////////
  // per eew product views
  //////////////////////////////////////////////////
  always_comb begin
    for (int g = 0; g < NUM_GRPS; g++) begin
      for (int e = 0; e < GB; e++) begin
        prod.p8[g*GB+e] = 16'(sum_terms(pp, g, e, 1, dst_signed, src1_signed));  // diagonal
      end
      for (int h = 0; h < GB / 2; h++) begin
        prod.p16[g*(GB/2)+h] = 32'(sum_terms(pp, g, 2 * h, 2, dst_signed, src1_signed));
      end
      prod.p32[g] = sum_terms(pp, g, 0, GB, dst_signed, src1_signed);
    end
  end

endmodule

/* src/mul_writeback.sv */
/*
 Result select, vsmul rounding and saturation, and vxsat.
 vsmul saturates only for min x min and returns the largest positive value.
 w_data is only meaningful while rslt_valid is high.
*/
`timescale 1ns/1ps
`include "vmul_cfg.svh"

module mul_writeback (
  input  logic                 pp_valid,
  input  vmul_pkg::full_prod_t prod,
  input  vmul_pkg::mul_ctrl_t  pp_ctrl,
  output logic                 rslt_valid,
  output vmul_pkg::mul_rslt_t  rslt
);
  import vmul_pkg::*;

  localparam int N8  = `VMUL_NUM_BYTES;
  localparam int N16 = `VMUL_NUM_BYTES / 2;
  localparam int N32 = `VMUL_NUM_BYTES / 4;

  logic [`VMUL_VLEN-1:0] res8;
  logic [`VMUL_VLEN-1:0] res16;
  logic [`VMUL_VLEN-1:0] res32;
  logic [N8-1:0]         sat8;
  logic [N16-1:0]        sat16;
  logic [N32-1:0]        sat32;
  logic [`VMUL_VLEN-1:0] w_data;
  logic                  sat_any;

  // one element of width sew, returns {sat, data}; data valid in [sew-1:0]
  function automatic logic [32:0] lane_calc(
    input logic [63:0] p,
    input int unsigned sew,
    input logic        keep_low,
    input logic        is_vsmul,
    input vxrm_e       vxrm
  );
    logic        lsb;
    logic        half;
    logic        rest;
    logic        below;
    logic        rnd;
    logic        sat;
    logic [31:0] data;
    lsb   = p[sew-1];  // lsb of the shifted result
    half  = p[sew-2];
    rest  = |(p & ((64'd1 << (sew - 2)) - 64'd1));
    below = |(p & ((64'd1 << (sew - 1)) - 64'd1));
    case (vxrm)
      rnu:     rnd = half;
      rne:     rnd = half & (rest | lsb);
      rdn:     rnd = 1'b0;
      default: rnd = ~lsb & below;  // rod
    endcase
    sat = ~p[2*sew-1] & p[2*sew-2];  // only min x min reaches 2^(2sew-2)
    if (is_vsmul) begin
      data = sat ? 32'((64'd1 << (sew - 1)) - 64'd1) : 32'(p >> (sew - 1)) + 32'(rnd);
    end else if (keep_low) begin
      data = p[31:0];
    end else begin
      data = 32'(p >> sew);
    end
    return {sat & is_vsmul, data};
  endfunction

  //////////////////////////////////////////////////
  // per eew lanes
  //////////////////////////////////////////////////
  always_comb begin
    logic [32:0] lane;
    for (int i = 0; i < N8; i++) begin
      lane = lane_calc(64'(prod.p8[i]), 8, pp_ctrl.keep_low, pp_ctrl.is_vsmul, pp_ctrl.vxrm);
      res8[i*8 +: 8] = lane[7:0];
      sat8[i]        = lane[32];
    end
    for (int i = 0; i < N16; i++) begin
      lane = lane_calc(64'(prod.p16[i]), 16, pp_ctrl.keep_low, pp_ctrl.is_vsmul, pp_ctrl.vxrm);
      res16[i*16 +: 16] = lane[15:0];
      sat16[i]          = lane[32];
    end
    for (int i = 0; i < N32; i++) begin
      lane = lane_calc(prod.p32[i], 32, pp_ctrl.keep_low, pp_ctrl.is_vsmul, pp_ctrl.vxrm);
      res32[i*32 +: 32] = lane[31:0];
      sat32[i]          = lane[32];
    end
  end

  always_comb begin
    case (pp_ctrl.eew)
      eew32: begin
        w_data  = res32;
        sat_any = |sat32;
      end
      eew16: begin
        w_data  = res16;
        sat_any = |sat16;
      end
      default: begin  // eew8 and unused code
        w_data  = res8;
        sat_any = |sat8;
      end
    endcase
  end

  assign rslt_valid = pp_valid;
  assign rslt = '{rob_entry: pp_ctrl.rob_entry, w_data: w_data, vxsat: pp_valid & sat_any};

endmodule

/* src/vmul_unit.sv */
/*
 Vector integer multiply unit, one uop per cycle, result 1 cycle later.
 Valid-only interface with no back-pressure; rslt must always be taken.
 Results leave in issue order with rob_entry carried through.
*/
`timescale 1ns/1ps

module vmul_unit (
  input  logic                clk,
  input  logic                reset,
  input  logic                uop_valid,
  input  vmul_pkg::mul_uop_t  uop,
  output logic                rslt_valid,
  output vmul_pkg::mul_rslt_t rslt
);
  import vmul_pkg::*;

  mul_ops_t   ops;
  mul_ctrl_t  ctrl;
  logic       pp_valid;
  pp_vec_t    pp;
  mul_ctrl_t  pp_ctrl;
  full_prod_t prod;

  mul_decode u_mul_decode (
    .uop_valid (uop_valid),
    .uop       (uop),
    .ops       (ops),
    .ctrl      (ctrl)
  );

  mul_pp_array u_mul_pp_array (
    .clk       (clk),
    .reset     (reset),
    .uop_valid (uop_valid),
    .ops       (ops),
    .ctrl      (ctrl),
    .pp_valid  (pp_valid),
    .pp        (pp),
    .pp_ctrl   (pp_ctrl)
  );

  mul_assemble u_mul_assemble (
    .pp          (pp),
    .dst_signed  (pp_ctrl.dst_signed),
    .src1_signed (pp_ctrl.src1_signed),
    .prod        (prod)
  );

  mul_writeback u_mul_writeback (
    .pp_valid   (pp_valid),
    .prod       (prod),
    .pp_ctrl    (pp_ctrl),
    .rslt_valid (rslt_valid),
    .rslt       (rslt)
  );

endmodule

/* verif/vmul_assertions.sv */
/*
 Port-level timing checks on vmul_unit, attached by bind.
 Timing checks are skipped while reset is high.
*/
`timescale 1ns/1ps

module vmul_assertions (
  input logic                clk,
  input logic                reset,
  input logic                uop_valid,
  input vmul_pkg::mul_uop_t  uop,
  input logic                rslt_valid,
  input vmul_pkg::mul_rslt_t rslt
);

  int fail_count;  // read by the testbench at the end

  reset_clears_valid: assert property (@(posedge clk) reset |=> !rslt_valid)
    else begin
      $error("rslt_valid high right after a reset cycle");
      fail_count++;
    end

  valid_follows_issue: assert property (
    @(posedge clk) disable iff (reset) uop_valid |=> rslt_valid)
    else begin
      $error("no rslt_valid one cycle after uop_valid");
      fail_count++;
    end

  no_spurious_valid: assert property (
    @(posedge clk) disable iff (reset) !uop_valid |=> !rslt_valid)
    else begin
      $error("rslt_valid without a uop the cycle before");
      fail_count++;
    end

  rob_carried: assert property (
    @(posedge clk) disable iff (reset)
    uop_valid |=> rslt.rob_entry == $past(uop.rob_entry))
    else begin
      $error("rob_entry changed between issue and write-back");
      fail_count++;
    end

endmodule

/* verif/vmul_checker.sv */
/*
 Scoreboard for vmul_unit with its own element-level model.
 Expects every accepted uop back exactly one cycle later, in order.
*/
`timescale 1ns/1ps
`include "vmul_cfg.svh"

module vmul_checker (
  input  logic                clk,
  input  logic                reset,
  input  logic                uop_valid,
  input  vmul_pkg::mul_uop_t  uop,
  input  logic                rslt_valid,
  input  vmul_pkg::mul_rslt_t rslt,
  output int                  err_count,
  output int                  chk_count,
  output int                  pending
);
  import vmul_pkg::*;

  mul_rslt_t exp_q[$];
  mul_rslt_t exp_r;

  // expected write-back of one uop, element by element
  function automatic mul_rslt_t model(input mul_uop_t u);
    mul_rslt_t   r;
    int          sew;
    logic        s2;
    logic        s1;
    logic        hi;
    logic        sm;
    logic        vx;
    logic        rnd;
    logic        lsb;
    logic        lower;
    logic        below;
    logic [63:0] mask;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] p;
    logic [63:0] e;
    r = '{rob_entry: u.rob_entry, w_data: '0, vxsat: 1'b0};
    case (u.eew)
      eew16:   sew = 16;
      eew32:   sew = 32;
      default: sew = 8;
    endcase
    mask = (64'd1 << sew) - 64'd1;
    s2   = 1'b1;
    s1   = 1'b1;
    hi   = 1'b0;
    sm   = 1'b0;
    vx   = (u.funct3 == opivx) || (u.funct3 == opmvx);
    case (u.funct3)
      opmvv, opmvx: begin
        case (u.funct6)
          vmulh: hi = 1'b1;
          vmulhu: begin
            hi = 1'b1;
            s2 = 1'b0;
            s1 = 1'b0;
          end
          vmulhsu: begin
            hi = 1'b1;
            s1 = 1'b0;  // vs1 or rs1 unsigned
          end
          default: hi = 1'b0;  // vmul and unknown codes
        endcase
      end
      opivv, opivx: sm = 1'b1;
      default: return r;  // unsupported category gives zero
    endcase
    for (int i = 0; i < `VMUL_VLEN / sew; i++) begin
      a = 64'(u.vs2_data >> (i * sew)) & mask;
      b = vx ? (64'(u.rs1_data) & mask) : (64'(u.vs1_data >> (i * sew)) & mask);
      if (sm && a == (64'd1 << (sew - 1)) && b == (64'd1 << (sew - 1))) begin
        e       = mask >> 1;  // largest positive
        r.vxsat = 1'b1;
      end else begin
        if (s2 && a[sew-1]) a = a | ~mask;
        if (s1 && b[sew-1]) b = b | ~mask;
        p = a * b;
        if (sm) begin
          lsb   = p[sew-1];
          lower = |(p & ((64'd1 << (sew - 2)) - 64'd1));
          below = |(p & ((64'd1 << (sew - 1)) - 64'd1));
          case (u.vxrm)
            rnu:     rnd = p[sew-2];
            rne:     rnd = p[sew-2] & (lower | lsb);
            rdn:     rnd = 1'b0;
            default: rnd = ~lsb & below;  // rod
          endcase
          e = ((p >> (sew - 1)) + 64'(rnd)) & mask;
        end else if (hi) begin
          e = (p >> sew) & mask;
        end else begin
          e = p & mask;
        end
      end
      r.w_data = r.w_data | (128'(e) << (i * sew));
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////
  // pop and compare, then queue the new uop
  ////////////////////////////////////////////////////
  always @(posedge clk) begin
    if (reset) begin
      exp_q.delete();
      err_count = 0;
      chk_count = 0;
    end else begin
      if (rslt_valid) begin
        if (exp_q.size() == 0) begin
          $display("result returned with no uop issued the cycle before");
          err_count++;
        end else begin
          exp_r = exp_q.pop_front();
          chk_count++;
          if (rslt.rob_entry !== exp_r.rob_entry) begin
            $display("** Error: rslt.rob_entry expected %h actual %h",
                     exp_r.rob_entry, rslt.rob_entry);
            err_count++;
          end
          if (rslt.w_data !== exp_r.w_data) begin
            $display("** Error: rslt.w_data rob %h expected %h actual %h",
                     exp_r.rob_entry, exp_r.w_data, rslt.w_data);
            err_count++;
          end
          if (rslt.vxsat !== exp_r.vxsat) begin
            $display("** Error: rslt.vxsat rob %h expected %h actual %h",
                     exp_r.rob_entry, exp_r.vxsat, rslt.vxsat);
            err_count++;
          end
        end
      end else if (exp_q.size() != 0) begin
        $display("no result one cycle after issue of rob entry %0h", exp_q[0].rob_entry);
        err_count++;
        exp_q.delete();
      end
      if (uop_valid) exp_q.push_back(model(uop));
    end
    pending = exp_q.size();
  end

endmodule

/* verif/tb_vmul_unit.sv */
/*
 Testbench for vmul_unit, five tests of 64 issue slots each.
 One slot per clock; an idle slot drives uop_valid low.
*/
`timescale 1ns/1ps
`include "vmul_cfg.svh"

module tb_vmul_unit;
  import vmul_pkg::*;

  localparam int          NUM_TESTS     = 5;
  localparam int          UOPS_PER_TEST = 64;
  localparam int          CLK_PERIOD    = 4;
  localparam logic [15:0] SEED          = 16'd26902;
  localparam int          WATCHDOG_NS   = (NUM_TESTS * UOPS_PER_TEST + 20) * CLK_PERIOD;

  logic        clk;
  logic        reset;
  logic        uop_valid;
  mul_uop_t    uop;
  logic        rslt_valid;
  mul_rslt_t   rslt;
  int          err_count;
  int          chk_count;
  int          pending;
  int          tb_errs;
  logic [15:0] lfsr;

  vmul_unit u_vmul_unit (
    .clk        (clk),
    .reset      (reset),
    .uop_valid  (uop_valid),
    .uop        (uop),
    .rslt_valid (rslt_valid),
    .rslt       (rslt)
  );

  vmul_checker u_vmul_checker (
    .clk        (clk),
    .reset      (reset),
    .uop_valid  (uop_valid),
    .uop        (uop),
    .rslt_valid (rslt_valid),
    .rslt       (rslt),
    .err_count  (err_count),
    .chk_count  (chk_count),
    .pending    (pending)
  );

  bind vmul_unit vmul_assertions u_vmul_assertions (
    .clk        (clk),
    .reset      (reset),
    .uop_valid  (uop_valid),
    .uop        (uop),
    .rslt_valid (rslt_valid),
    .rslt       (rslt)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before all tests finished");
    $display("Regression failed");
    $finish;
  end

  // taps 16 14 13 11
  function automatic logic [15:0] next_lfsr(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic get_bits(input int n, output logic [`VMUL_VLEN-1:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = next_lfsr(lfsr);
      v[i] = lfsr[0];  // one step per bit
    end
  endtask

  function automatic logic [`VMUL_VLEN-1:0] min_pattern(input eew_e eew);
    case (eew)
      eew16:   return {8{16'h8000}};
      eew32:   return {4{32'h8000_0000}};
      default: return {16{8'h80}};
    endcase
  endfunction

  function automatic string test_name(input int t);
    case (t)
      0:       return "vv_mul_ops";
      1:       return "vx_broadcast";
      2:       return "vsmul_rounding";
      3:       return "back_to_back";
      default: return "bad_funct3";
    endcase
  endfunction

  ////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////
  task automatic build_uop(input int mode, output logic valid, output mul_uop_t u);
    logic [`VMUL_VLEN-1:0] r;
    logic [`VMUL_VLEN-1:0] mn;
    get_bits(`VMUL_VLEN, r);
    u.vs2_data = r;
    get_bits(`VMUL_VLEN, r);
    u.vs1_data = r;
    get_bits(`VMUL_XLEN, r);
    u.rs1_data = r[`VMUL_XLEN-1:0];
    get_bits(`VMUL_ROB_W, r);
    u.rob_entry = r[`VMUL_ROB_W-1:0];
    get_bits(2, r);
    u.vxrm = vxrm_e'(r[1:0]);
    get_bits(2, r);
    u.eew = (r[1:0] == 2'd3) ? eew8 : eew_e'(r[1:0]);
    get_bits(8, r);
    case (r[2:0])
      3'd0, 3'd1: u.funct6 = vmul;
      3'd2:       u.funct6 = vmulh;
      3'd3:       u.funct6 = vmulhu;
      3'd4, 3'd5: u.funct6 = vmulhsu;
      default:    u.funct6 = funct6_e'({1'b0, r[7:3]});  // undefined code
    endcase
    get_bits(2, r);
    case (mode)
      0:       u.funct3 = opmvv;
      1:       u.funct3 = opmvx;
      2:       u.funct3 = r[0] ? opivx : opivv;
      3:       u.funct3 = funct3_e'({r[1:0], 1'b0});  // any supported category
      default: u.funct3 = funct3_e'({r[1:0], 1'b1});  // unsupported codes only
    endcase
    get_bits(2, r);
    if (mode == 2 && r[0]) begin
      mn         = min_pattern(u.eew);
      u.vs2_data = mn;
      u.rs1_data = mn[`VMUL_XLEN-1:0];
      u.vs1_data = r[1] ? mn : {u.vs1_data[`VMUL_VLEN-1:32], mn[31:0]};  // low lanes only
    end
    get_bits(2, r);
    valid = (mode == 3) || (r[1:0] != 2'd0);
  endtask

  task automatic run_test(input int mode);
    logic     v;
    mul_uop_t u;
    for (int i = 0; i < UOPS_PER_TEST; i++) begin
      build_uop(mode, v, u);
      @(posedge clk);
      #1;
      uop_valid = v;
      uop       = u;
    end
    @(posedge clk);
    #1;
    uop_valid = 1'b0;
    do begin
      @(posedge clk);
      #1;
    end while (pending != 0);
  endtask

  initial begin
    int err_before;
    int chk_before;
    int asrt_errs;
    reset     = 1'b1;
    uop_valid = 1'b0;
    uop       = '0;
    tb_errs   = 0;
    lfsr      = SEED;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    if (rslt_valid !== 1'b0) begin
      $display("rslt_valid is not low after reset");
      tb_errs++;
    end
    for (int t = 0; t < NUM_TESTS; t++) begin
      err_before = err_count;
      chk_before = chk_count;
      run_test(t);
      $display("test %0d %s: %0d results checked, %0d errors", t, test_name(t),
               chk_count - chk_before, err_count - err_before);
    end
    asrt_errs = u_vmul_unit.u_vmul_assertions.fail_count;
    $display("summary: %0d tests, %0d results, %0d checker errors, %0d assertion failures",
             NUM_TESTS, chk_count, err_count + tb_errs, asrt_errs);
    if (err_count + tb_errs + asrt_errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+src
src/vmul_pkg.sv
src/mul_decode.sv
src/mul_pp_array.sv
src/mul_assemble.sv
src/mul_writeback.sv
src/vmul_unit.sv
verif/vmul_assertions.sv
verif/vmul_checker.sv
verif/tb_vmul_unit.sv

/* Makefile */
# Verilator build and run for the vector multiply unit

VERILATOR ?= verilator
TOP       ?= tb_vmul_unit
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Regression passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
